//--- verilog/axi_bus_pkg.sv
package axi_bus_pkg;

  // ********************************************************************
  // bus widths
  // ********************************************************************
  localparam int unsigned AXI_ADDR_W = 32;
  localparam int unsigned AXI_DATA_W = 128;
  localparam int unsigned AXI_ID_W   = 4;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;

  // burst and response codes
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  // ********************************************************************
  // write channel payloads
  // ********************************************************************
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [3:0]            cache;
    logic [2:0]            prot;
    logic                  lock;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

endpackage

//--- verilog/wr_job_pkg.sv
package wr_job_pkg;

  // beat count over a whole job
  typedef logic [15:0] beat_cnt_t;

  // bursts per job
  typedef logic [11:0] burst_cnt_t;

  // one word from the sample source
  typedef logic [127:0] sample_t;

  // ********************************************************************
  // job status flags
  // ********************************************************************
  typedef struct packed {
    logic busy;
    logic aw_done;
    logic w_done;
    logic err;
  } job_status_t;

endpackage

//--- verilog/axi_chan_slice.sv
`timescale 1ns/1ns

module axi_chan_slice #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic rst_n,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T     data_q;
  logic valid_q;

  // free when empty or when the held entry leaves this cycle
  assign o_ready = !valid_q || i_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (i_valid && o_ready) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      data_q <= i_data;
    end
  end

  assign o_data  = data_q;
  assign o_valid = valid_q;

  // a stalled transfer keeps valid and payload
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

//--- verilog/axi_aw_issue.sv
`timescale 1ns/1ns

module axi_aw_issue import axi_bus_pkg::*, wr_job_pkg::*; #(
  parameter int unsigned BURST_LEN    = 8,
  parameter int unsigned NUM_BURSTS   = 128,
  parameter int unsigned REGION_BYTES = 16384
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_job_start,
  output axi_aw_t o_req,
  output logic    o_req_valid,
  input  logic    i_req_ready,
  output logic    o_aw_done
);

  localparam logic [AXI_ADDR_W-1:0] BURST_BYTES = AXI_ADDR_W'(BURST_LEN * AXI_STRB_W);
  localparam logic [AXI_ADDR_W-1:0] REGION_TOP  = AXI_ADDR_W'(REGION_BYTES);

  logic [AXI_ADDR_W-1:0] addr;
  logic [AXI_ADDR_W-1:0] next_addr;
  burst_cnt_t            burst_cnt;
  logic                  req_fire;

  assign req_fire  = o_req_valid && i_req_ready;
  assign next_addr = addr + BURST_BYTES;

  // ********************************************************************
  // burst counter and request valid
  // ********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_req_valid <= 1'b0;
      o_aw_done   <= 1'b0;
      burst_cnt   <= '0;
    end else if (i_job_start) begin
      o_req_valid <= 1'b1;
      o_aw_done   <= 1'b0;
      burst_cnt   <= '0;
    end else if (req_fire) begin
      burst_cnt <= burst_cnt + 1'b1;
      if (burst_cnt == burst_cnt_t'(NUM_BURSTS - 1)) begin
        o_req_valid <= 1'b0;
        o_aw_done   <= 1'b1;
      end
    end
  end

  // rolling address kept from job to job
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (req_fire) begin
      addr <= (next_addr >= REGION_TOP) ? '0 : next_addr;
    end
  end

  // fixed INCR request around the running address
  always_comb begin
    o_req.id    = AXI_ID_W'(1);
    o_req.addr  = addr;
    o_req.len   = 8'(BURST_LEN - 1);
    o_req.size  = 3'($clog2(AXI_STRB_W));
    o_req.burst = AXI_BURST_INCR;
    o_req.cache = 4'b0000;
    o_req.prot  = 3'b000;
    o_req.lock  = 1'b0;
  end

  // every burst ends inside the region
  a_addr_range : assert property (@(posedge clk) disable iff (!rst_n)
    o_req_valid |-> next_addr <= REGION_TOP);

endmodule

//--- verilog/axi_w_stream.sv
`timescale 1ns/1ns

module axi_w_stream import axi_bus_pkg::*, wr_job_pkg::*; #(
  parameter int unsigned BURST_LEN  = 8,
  parameter int unsigned NUM_BURSTS = 128
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_job_start,
  output logic    o_data_req,
  input  logic    i_data_valid,
  input  sample_t i_data,
  output axi_w_t  o_beat,
  output logic    o_beat_valid,
  input  logic    i_beat_ready,
  output logic    o_w_done
);

  localparam int unsigned TOTAL_BEATS = NUM_BURSTS * BURST_LEN;

  logic      active;
  beat_cnt_t beat_cnt;
  beat_cnt_t burst_beat;
  logic      beat_fire;
  logic      last_beat;

  // sample taken only when the slice has room
  assign o_data_req   = active && i_beat_ready;
  assign o_beat_valid = i_data_valid && o_data_req;
  assign beat_fire    = o_beat_valid && i_beat_ready;
  assign last_beat    = burst_beat == beat_cnt_t'(BURST_LEN - 1);

  // ********************************************************************
  // beat counters
  // ********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      o_w_done   <= 1'b0;
      beat_cnt   <= '0;
      burst_beat <= '0;
    end else if (i_job_start) begin
      active     <= 1'b1;
      o_w_done   <= 1'b0;
      beat_cnt   <= '0;
      burst_beat <= '0;
    end else if (beat_fire) begin
      beat_cnt   <= beat_cnt + 1'b1;
      burst_beat <= last_beat ? '0 : burst_beat + 1'b1;
      // job's final sample
      if (beat_cnt == beat_cnt_t'(TOTAL_BEATS - 1)) begin
        active   <= 1'b0;
        o_w_done <= 1'b1;
      end
    end
  end

  always_comb begin
    o_beat.data = i_data;
    o_beat.strb = '1;
    o_beat.last = last_beat;
  end

  a_valid_only_on_req : assert property (@(posedge clk) disable iff (!rst_n)
    i_data_valid |-> o_data_req);

endmodule

//--- verilog/axi_wr_tracker.sv
`timescale 1ns/1ns

module axi_wr_tracker import axi_bus_pkg::*, wr_job_pkg::*; #(
  parameter int unsigned NUM_BURSTS = 128
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_start,
  output logic        o_job_start,
  input  logic        i_aw_done,
  input  logic        i_w_done,
  input  axi_b_t      i_b,
  input  logic        i_b_valid,
  output logic        o_b_ready,
  output job_status_t o_status,
  output logic        o_end
);

  logic       busy;
  logic       err;
  logic       resp_done;
  burst_cnt_t b_cnt;
  logic       b_fire;
  logic       b_last;
  logic       finish;

  // start ignored while a job runs
  assign o_job_start = i_start && !busy;

  assign b_fire = i_b_valid && o_b_ready;
  assign b_last = b_fire && (b_cnt == burst_cnt_t'(NUM_BURSTS - 1));
  assign finish = busy && i_aw_done && i_w_done && (b_last || resp_done);

  // ********************************************************************
  // job state and response count
  // ********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      err       <= 1'b0;
      resp_done <= 1'b0;
      b_cnt     <= '0;
      o_end     <= 1'b0;
      o_b_ready <= 1'b0;
    end else begin
      o_b_ready <= 1'b1;
      o_end     <= finish;
      if (o_job_start) begin
        busy      <= 1'b1;
        err       <= 1'b0;
        resp_done <= 1'b0;
        b_cnt     <= '0;
      end else begin
        if (finish) begin
          busy <= 1'b0;
        end
        if (b_fire) begin
          b_cnt <= b_cnt + 1'b1;
          if (i_b.resp != AXI_RESP_OKAY) begin
            err <= 1'b1;
          end
        end
        if (b_last) begin
          resp_done <= 1'b1;
        end
      end
    end
  end

  assign o_status = '{busy: busy, aw_done: i_aw_done, w_done: i_w_done, err: err};

endmodule

//--- verilog/axi4_master_write.sv
`timescale 1ns/1ns

module axi4_master_write import axi_bus_pkg::*, wr_job_pkg::*; #(
  parameter int unsigned BURST_LEN    = 8,
  parameter int unsigned NUM_BURSTS   = 128,
  parameter int unsigned REGION_BYTES = 16384
) (
  input  logic    clk,
  input  logic    rst_n,
  // job control
  input  logic    i_start,
  output logic    o_busy,
  output logic    o_end,
  output logic    o_err,
  // sample source
  output logic    o_data_req,
  input  logic    i_data_valid,
  input  sample_t i_data,
  // axi write channels
  output axi_aw_t o_aw,
  output logic    o_aw_valid,
  input  logic    i_aw_ready,
  output axi_w_t  o_w,
  output logic    o_w_valid,
  input  logic    i_w_ready,
  input  axi_b_t  i_b,
  input  logic    i_b_valid,
  output logic    o_b_ready
);

  logic        job_start;
  logic        aw_done;
  logic        w_done;
  job_status_t status;

  axi_aw_t     aw_req;
  logic        aw_req_valid;
  logic        aw_req_ready;
  axi_w_t      beat;
  logic        beat_valid;
  logic        beat_ready;

  // ********************************************************************
  // address path
  // ********************************************************************
  axi_aw_issue #(
    .BURST_LEN    (BURST_LEN),
    .NUM_BURSTS   (NUM_BURSTS),
    .REGION_BYTES (REGION_BYTES)
  ) axi_aw_issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_job_start (job_start),
    .o_req       (aw_req),
    .o_req_valid (aw_req_valid),
    .i_req_ready (aw_req_ready),
    .o_aw_done   (aw_done)
  );

  axi_chan_slice #(.T(axi_aw_t)) aw_slice_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_data  (aw_req),
    .i_valid (aw_req_valid),
    .o_ready (aw_req_ready),
    .o_data  (o_aw),
    .o_valid (o_aw_valid),
    .i_ready (i_aw_ready)
  );

  // ********************************************************************
  // data path
  // ********************************************************************
  axi_w_stream #(
    .BURST_LEN  (BURST_LEN),
    .NUM_BURSTS (NUM_BURSTS)
  ) axi_w_stream_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_job_start  (job_start),
    .o_data_req   (o_data_req),
    .i_data_valid (i_data_valid),
    .i_data       (i_data),
    .o_beat       (beat),
    .o_beat_valid (beat_valid),
    .i_beat_ready (beat_ready),
    .o_w_done     (w_done)
  );

  axi_chan_slice #(.T(axi_w_t)) w_slice_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_data  (beat),
    .i_valid (beat_valid),
    .o_ready (beat_ready),
    .o_data  (o_w),
    .o_valid (o_w_valid),
    .i_ready (i_w_ready)
  );

  // responses and job end
  axi_wr_tracker #(
    .NUM_BURSTS (NUM_BURSTS)
  ) axi_wr_tracker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .o_job_start (job_start),
    .i_aw_done   (aw_done),
    .i_w_done    (w_done),
    .i_b         (i_b),
    .i_b_valid   (i_b_valid),
    .o_b_ready   (o_b_ready),
    .o_status    (status),
    .o_end       (o_end)
  );

  assign o_busy = status.busy;
  assign o_err  = status.err;

endmodule

//--- tests/tb_axi4_master_write.sv
`timescale 1ns/1ns

module tb_axi4_master_write import axi_bus_pkg::*, wr_job_pkg::*; ();

  localparam int unsigned BURST_LEN    = 8;
  localparam int unsigned NUM_BURSTS   = 4;
  localparam int unsigned REGION_BYTES = 512;
  localparam int unsigned NUM_JOBS     = 4;
  localparam int unsigned JOB_BEATS    = NUM_BURSTS * BURST_LEN;
  localparam int unsigned CYCLE_LIMIT  = 20 * NUM_JOBS * JOB_BEATS + 200;
  // job and burst that get a SLVERR back
  localparam int unsigned ERR_JOB      = 1;
  localparam int unsigned ERR_BURST    = 2;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    i_start;
  logic    o_busy;
  logic    o_end;
  logic    o_err;
  logic    o_data_req;
  logic    i_data_valid;
  sample_t i_data;
  axi_aw_t o_aw;
  logic    o_aw_valid;
  logic    i_aw_ready;
  axi_w_t  o_w;
  logic    o_w_valid;
  logic    i_w_ready;
  axi_b_t  i_b;
  logic    i_b_valid;
  logic    o_b_ready;

  // ********************************************************************
  // model state
  // ********************************************************************
  logic [AXI_ADDR_W-1:0] exp_addr_q[$];
  sample_t               exp_data_q[$];
  int unsigned           b_due_q[$];
  int unsigned           next_addr = 0;
  int unsigned           cycle     = 0;
  int unsigned           tick      = 0;
  int unsigned           job       = 0;
  int unsigned           started   = 0;
  int unsigned           taken     = 0;
  int unsigned           job_aw    = 0;
  int unsigned           job_beats = 0;
  int unsigned           job_b     = 0;
  int unsigned           b_total   = 0;
  int unsigned           aw_total  = 0;
  int unsigned           ends      = 0;
  int unsigned           checks    = 0;
  int unsigned           errors    = 0;
  int unsigned           err_base  = 0;
  logic                  src_on    = 1'b0;
  logic                  end_seen  = 1'b0;
  string test_names [NUM_JOBS] = '{"addr_wrap", "slverr_resp", "err_clear", "busy_start"};

  always #4 clk = ~clk;

  axi4_master_write #(
    .BURST_LEN    (BURST_LEN),
    .NUM_BURSTS   (NUM_BURSTS),
    .REGION_BYTES (REGION_BYTES)
  ) axi4_master_write_i (.*);

  task automatic expect_eq(input string what, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (exp === act) else begin
      $display("FAIL %s %s expected %0h actual %0h", test_names[job], what, exp, act);
      errors++;
    end
  endtask

  task automatic require_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("ERROR %s: %s", test_names[job], msg);
      errors++;
    end
  endtask

  // one job with an optional second start while it runs
  task automatic run_job(input logic extra_start);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    @(posedge clk);
    require_true(!o_err, "o_err still set after a new job started");
    if (extra_start) begin
      repeat (4) @(posedge clk);
      require_true(o_busy, "job ended before the start given during it");
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
    end
    do begin
      @(posedge clk);
    end while (!o_end);
  endtask

  // ********************************************************************
  // slave responder, sample source and monitors
  // ********************************************************************
  initial begin
    logic took;
    logic new_w_ready;
    void'($urandom(59440));
    forever begin
      @(posedge clk);
      tick++;
      if (rst_n) begin
        took = i_data_valid && o_data_req;
        if (i_start && !o_busy) begin
          job       = started;
          started++;
          err_base  = errors;
          taken     = 0;
          job_aw    = 0;
          job_beats = 0;
          job_b     = 0;
          end_seen  = 1'b0;
          src_on    = 1'b1;
          for (int n = 0; n < NUM_BURSTS; n++) begin
            exp_addr_q.push_back(next_addr);
            next_addr = (next_addr + BURST_LEN * 16) % REGION_BYTES;
          end
        end
        if (i_data_valid) begin
          require_true(o_data_req, "i_data_valid given while o_data_req low");
        end
        if (i_b_valid) begin
          require_true(o_b_ready, "o_b_ready low while a response is offered");
        end
        if (o_w_valid && i_w_ready) begin
          if (exp_data_q.size() == 0) begin
            require_true(1'b0, "W beat with no sample behind it");
          end else begin
            expect_eq("wdata", exp_data_q.pop_front(), o_w.data);
          end
          expect_eq("wstrb", {AXI_STRB_W{1'b1}}, o_w.strb);
          expect_eq("wlast", (job_beats % BURST_LEN) == BURST_LEN - 1, o_w.last);
          job_beats++;
          if (o_w.last) begin
            b_due_q.push_back(tick + $urandom_range(0, 6));
          end
        end
        if (took) begin
          exp_data_q.push_back(i_data);
          taken++;
        end
        if (o_aw_valid && i_aw_ready) begin
          if (exp_addr_q.size() == 0) begin
            require_true(1'b0, "AW transfer beyond the bursts of the started jobs");
          end else begin
            expect_eq("awaddr", exp_addr_q.pop_front(), o_aw.addr);
          end
          expect_eq("awlen", BURST_LEN - 1, o_aw.len);
          expect_eq("awsize", 4, o_aw.size);
          expect_eq("awburst", 2'b01, o_aw.burst);
          expect_eq("awid", 1, o_aw.id);
          job_aw++;
          aw_total++;
        end
        if (i_b_valid && o_b_ready) begin
          job_b++;
          b_total++;
        end
        if (o_end) begin
          require_true(!end_seen, "o_end pulsed more than once in one job");
          require_true(!o_busy, "o_busy still high while o_end pulses");
          expect_eq("bursts", NUM_BURSTS, job_aw);
          expect_eq("beats", JOB_BEATS, job_beats);
          expect_eq("responses", NUM_BURSTS, job_b);
          expect_eq("o_err", job == ERR_JOB, o_err);
          end_seen = 1'b1;
          ends++;
          $display("test %s done, %0d errors", test_names[job], errors - err_base);
        end
        // next B only once its AW has been seen
        if (i_b_valid && !o_b_ready) begin
          i_b_valid <= 1'b1;
        end else if (b_due_q.size() > 0 && b_due_q[0] <= tick && b_total < aw_total) begin
          void'(b_due_q.pop_front());
          i_b_valid <= 1'b1;
          i_b.id    <= 4'd1;
          i_b.resp  <= (job == ERR_JOB && job_b == ERR_BURST) ? 2'b10 : 2'b00;
        end else begin
          i_b_valid <= 1'b0;
        end
        if (taken == JOB_BEATS) begin
          src_on = 1'b0;
        end
        // offer a sample only when the W slice will have room next cycle
        new_w_ready = $urandom_range(0, 3) != 0;
        i_w_ready  <= new_w_ready;
        i_aw_ready <= $urandom_range(0, 2) != 0;
        if (src_on && (new_w_ready || !(took || (o_w_valid && !i_w_ready))) &&
            $urandom_range(0, 3) != 0) begin
          i_data_valid <= 1'b1;
          i_data       <= {$urandom, $urandom, $urandom, $urandom};
        end else begin
          i_data_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    while (cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle++;
    end
    $display("ERROR run stopped after %0d cycles, job %0d never finished", cycle, job);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    i_start      = 1'b0;
    i_data_valid = 1'b0;
    i_data       = '0;
    i_aw_ready   = 1'b0;
    i_w_ready    = 1'b0;
    i_b          = '0;
    i_b_valid    = 1'b0;
    repeat (8) @(posedge clk);
    require_true(!(o_busy || o_end || o_aw_valid || o_w_valid || o_data_req),
                 "outputs not idle during reset");
    rst_n <= 1'b1;
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j == NUM_JOBS - 1);
    end
    repeat (20) @(posedge clk);
    expect_eq("jobs ended", NUM_JOBS, ends);
    expect_eq("total bursts", NUM_JOBS * NUM_BURSTS, aw_total);
    require_true(exp_data_q.size() == 0, "samples taken that never left as W beats");
    require_true(exp_addr_q.size() == 0, "expected bursts that never showed on AW");
    $display("tests %0d, checks %0d, errors %0d", ends, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/axi_bus_pkg.sv
verilog/wr_job_pkg.sv
verilog/axi_chan_slice.sv
verilog/axi_aw_issue.sv
verilog/axi_w_stream.sv
verilog/axi_wr_tracker.sv
verilog/axi4_master_write.sv
tests/tb_axi4_master_write.sv

//--- Bender.yml
package:
  name: axi4_master_write

sources:
  - verilog/axi_bus_pkg.sv
  - verilog/wr_job_pkg.sv
  - verilog/axi_chan_slice.sv
  - verilog/axi_aw_issue.sv
  - verilog/axi_w_stream.sv
  - verilog/axi_wr_tracker.sv
  - verilog/axi4_master_write.sv
  - target: test
    files:
      - tests/tb_axi4_master_write.sv
